//--- io_serdes.f
source/axis_stream_pkg.sv
source/serdes_lane_pkg.sv
source/link_control.sv
source/tx_serializer.sv
source/rx_deserializer.sv
source/io_serdes_top.sv
testbench/io_serdes_tb.sv

//--- Makefile
# Verilator build and run for the io_serdes loopback testbench
# any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= io_serdes_tb
FILELIST  ?= io_serdes.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "failure reported in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/io_serdes_tb.sv
`timescale 1ns/1ps

module io_serdes_tb;
	import axis_stream_pkg::*;
	import serdes_lane_pkg::*;

	localparam int NUM_ROWS   = 20;
	localparam int EDGE_LIMIT = 16; // clock edges allowed per frame wait

	typedef struct packed {
		data_t tdata;
		strb_t tstrb;
		strb_t tkeep;
		id_t   tid;
		user_t tuser;
		logic  tlast;
		logic  tvalid;
		logic  tready;
	} beat_t;

	// one row per frame, expected values are those seen at the boundary where the row is applied
	typedef struct packed {
		logic    txen_ctl;
		logic    rxen_ctl;
		beat_t   in_beat;  // driven on as_is_*
		beat_t   exp_beat; // is_as_*, tready holds is_as_tready
		serial_t exp_txd;  // serial_txd during phase 0
	} row_t;

	logic    ioclk;
	logic    axis_rst_n;
	logic    txen_ctl;
	logic    rxen_ctl;
	data_t   as_is_tdata;
	strb_t   as_is_tstrb;
	strb_t   as_is_tkeep;
	id_t     as_is_tid;
	user_t   as_is_tuser;
	logic    as_is_tlast;
	logic    as_is_tvalid;
	logic    as_is_tready;
	serial_t serial_txd;
	serial_t serial_rxd;
	data_t   is_as_tdata;
	strb_t   is_as_tstrb;
	strb_t   is_as_tkeep;
	id_t     is_as_tid;
	user_t   is_as_tuser;
	logic    is_as_tlast;
	logic    is_as_tvalid;
	logic    is_as_tready;

	row_t        stim [NUM_ROWS];
	int          edge_count;    // edges since reset release
	int          check_count;
	int          error_count;
	int          timeout_count;
	logic        timed_out;
	int unsigned seed_value;

	assign serial_rxd = serial_txd; // loopback

	io_serdes_top UUT (
		.ioclk        (ioclk),
		.axis_rst_n   (axis_rst_n),
		.txen_ctl     (txen_ctl),
		.rxen_ctl     (rxen_ctl),
		.as_is_tdata  (as_is_tdata),
		.as_is_tstrb  (as_is_tstrb),
		.as_is_tkeep  (as_is_tkeep),
		.as_is_tid    (as_is_tid),
		.as_is_tuser  (as_is_tuser),
		.as_is_tlast  (as_is_tlast),
		.as_is_tvalid (as_is_tvalid),
		.as_is_tready (as_is_tready),
		.serial_txd   (serial_txd),
		.serial_rxd   (serial_rxd),
		.is_as_tdata  (is_as_tdata),
		.is_as_tstrb  (is_as_tstrb),
		.is_as_tkeep  (is_as_tkeep),
		.is_as_tid    (is_as_tid),
		.is_as_tuser  (is_as_tuser),
		.is_as_tlast  (is_as_tlast),
		.is_as_tvalid (is_as_tvalid),
		.is_as_tready (is_as_tready)
	);

	initial begin
		ioclk = 1'b0;
		forever #2 ioclk = ~ioclk;
	end

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////

	// ctl is {txen_ctl, rxen_ctl, tlast, tvalid, tready}
	task automatic set_row(input int idx, input logic [4:0] ctl, input id_t tid,
			input user_t tuser, input logic quiet);
		stim[idx] = '0;
		stim[idx].txen_ctl       = ctl[4];
		stim[idx].rxen_ctl       = ctl[3];
		stim[idx].in_beat.tlast  = ctl[2];
		stim[idx].in_beat.tvalid = ctl[1];
		stim[idx].in_beat.tready = ctl[0];
		stim[idx].in_beat.tid    = tid;
		stim[idx].in_beat.tuser  = tuser;
		if (!quiet) begin
			stim[idx].in_beat.tdata = $urandom();
			stim[idx].in_beat.tstrb = strb_t'($urandom());
			stim[idx].in_beat.tkeep = strb_t'($urandom());
		end
	endtask

	task automatic fill_table();
		set_row(0,  5'b00_000, 2'd0, 2'd0, 1'b1);
		set_row(1,  5'b00_111, 2'd1, 2'd2, 1'b0); // offered while the link is off
		set_row(2,  5'b10_011, 2'd2, 2'd1, 1'b0); // txen sets at the end of this frame
		set_row(3,  5'b10_111, 2'd3, 2'd0, 1'b0); // sent while receive is still off
		set_row(4,  5'b10_000, 2'd0, 2'd0, 1'b1); // all zero frame ahead of rxen
		set_row(5,  5'b11_000, 2'd1, 2'd1, 1'b0); // flow lane zero
		set_row(6,  5'b11_011, 2'd2, 2'd1, 1'b0);
		set_row(7,  5'b11_111, 2'd3, 2'd3, 1'b0);
		set_row(8,  5'b11_010, 2'd0, 2'd2, 1'b0); // far side drops its ready
		set_row(9,  5'b11_010, 2'd1, 2'd0, 1'b0);
		set_row(10, 5'b11_111, 2'd2, 2'd2, 1'b0); // offered while is_as_tready is low
		set_row(11, 5'b11_011, 2'd3, 2'd1, 1'b0);
		set_row(12, 5'b11_001, 2'd0, 2'd3, 1'b0);
		set_row(13, 5'b11_011, 2'd1, 2'd1, 1'b0);
		set_row(14, 5'b11_111, 2'd2, 2'd0, 1'b0);
		set_row(15, 5'b11_000, 2'd3, 2'd2, 1'b0);
		set_row(16, 5'b11_011, 2'd0, 2'd1, 1'b0);
		set_row(17, 5'b11_110, 2'd1, 2'd3, 1'b0);
		set_row(18, 5'b11_011, 2'd2, 2'd0, 1'b0);
		set_row(19, 5'b11_011, 2'd3, 2'd2, 1'b0);
	endtask

	// lane levels while phase is 0, bit 0 of every lane
	function automatic serial_t first_phase_lanes(input beat_t frame, input logic tx_on);
		serial_t lanes;
		lanes = '0;
		if (tx_on) begin
			for (int j = 0; j < DATA_LANES; j++) begin
				lanes[j] = frame.tdata[CLK_RATIO * j];
			end
			lanes[LANE_STRB]    = frame.tstrb[0];
			lanes[LANE_KEEP]    = frame.tkeep[0];
			lanes[LANE_ID_USER] = frame.tuser[0];
			lanes[LANE_FLOW]    = frame.tready;
		end
		return lanes;
	endfunction

	// walks the table one frame boundary at a time
	task automatic predict_table();
		logic  txen_m;
		logic  rxen_m;
		logic  heard_m;   // received flag
		logic  seen_m;    // nonzero flow frame rebuilt at the last boundary
		logic  remote_m;
		logic  rxen_pre;
		logic  heard_pre;
		logic  ready_pre;
		logic  cur_txen;
		logic  cur_rxen;
		beat_t frame_m;   // beat on the wire during the next frame
		beat_t out_m;
		beat_t cur;
		txen_m   = 1'b0;
		rxen_m   = 1'b0;
		heard_m  = 1'b0;
		seen_m   = 1'b0;
		remote_m = 1'b0;
		cur_txen = 1'b0;
		cur_rxen = 1'b0;
		frame_m  = '0;
		cur      = '0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			rxen_pre  = rxen_m | cur_rxen;
			heard_pre = heard_m | seen_m;
			ready_pre = txen_m & (!heard_pre | remote_m);
			if (rxen_pre) begin
				out_m    = frame_m;
				seen_m   = frame_m.tlast | frame_m.tvalid | frame_m.tready;
				remote_m = frame_m.tready;
			end else begin
				out_m    = '0;
				seen_m   = 1'b0;
				remote_m = 1'b0;
			end
			if (txen_m) begin
				frame_m        = cur;
				frame_m.tvalid = cur.tvalid & ready_pre; // bubble without ready
			end else begin
				frame_m = '0;
			end
			txen_m  = txen_m | cur_txen | heard_pre;
			rxen_m  = rxen_pre;
			heard_m = heard_pre;
			stim[i].exp_beat        = out_m;
			stim[i].exp_beat.tready = ready_pre;
			stim[i].exp_txd         = first_phase_lanes(frame_m, txen_m);
			cur      = stim[i].in_beat;
			cur_txen = stim[i].txen_ctl;
			cur_rxen = stim[i].rxen_ctl;
		end
	endtask

	////////////////////////////////////////
	// drive, wait and check
	////////////////////////////////////////

	task automatic drive_inputs(input logic tx, input logic rx, input beat_t b);
		txen_ctl     = tx;
		rxen_ctl     = rx;
		as_is_tdata  = b.tdata;
		as_is_tstrb  = b.tstrb;
		as_is_tkeep  = b.tkeep;
		as_is_tid    = b.tid;
		as_is_tuser  = b.tuser;
		as_is_tlast  = b.tlast;
		as_is_tvalid = b.tvalid;
		as_is_tready = b.tready;
	endtask

	// phase 3 edge, found by counting edges since reset release
	task automatic wait_frame_edge(output logic expired);
		int waited;
		waited  = 0;
		expired = 1'b0;
		do begin
			@(posedge ioclk);
			edge_count++;
			waited++;
		end while (((edge_count % CLK_RATIO) != 0) && (waited < EDGE_LIMIT));
		if ((edge_count % CLK_RATIO) != 0) begin
			expired = 1'b1;
			timeout_count++;
			$display("timeout: no frame boundary within %0d clock edges", EDGE_LIMIT);
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_row(input int idx);
		beat_t e;
		e = stim[idx].exp_beat;
		check_field("is_as_tdata", 32'(is_as_tdata), 32'(e.tdata));
		check_field("is_as_tstrb", 32'(is_as_tstrb), 32'(e.tstrb));
		check_field("is_as_tkeep", 32'(is_as_tkeep), 32'(e.tkeep));
		check_field("is_as_tid", 32'(is_as_tid), 32'(e.tid));
		check_field("is_as_tuser", 32'(is_as_tuser), 32'(e.tuser));
		check_field("is_as_tlast", 32'(is_as_tlast), 32'(e.tlast));
		check_field("is_as_tvalid", 32'(is_as_tvalid), 32'(e.tvalid));
		check_field("is_as_tready", 32'(is_as_tready), 32'(e.tready));
		check_field("serial_txd", 32'(serial_txd), 32'(stim[idx].exp_txd));
	endtask

	initial begin
		axis_rst_n    = 1'b0;
		edge_count    = 0;
		check_count   = 0;
		error_count   = 0;
		timeout_count = 0;
		timed_out     = 1'b0;
		drive_inputs(1'b0, 1'b0, '0);
		seed_value = $urandom(32'hafd6135a);
		fill_table();
		predict_table();

		repeat (3) @(posedge ioclk);
		#1 axis_rst_n = 1'b1;

		for (int i = 0; i < NUM_ROWS; i++) begin
			wait_frame_edge(timed_out);
			if (timed_out) begin
				break;
			end
			#1;
			check_row(i); // outputs settle on the edge, inputs change after
			drive_inputs(stim[i].txen_ctl, stim[i].rxen_ctl, stim[i].in_beat);
		end

		$display("checks %0d, value errors %0d, timeouts %0d",
			check_count, error_count, timeout_count);
		if ((error_count == 0) && (timeout_count == 0)) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- source/io_serdes_top.sv
`timescale 1ns/1ps

module io_serdes_top (
	input  logic                     ioclk,
	input  logic                     axis_rst_n,
	input  logic                     txen_ctl,
	input  logic                     rxen_ctl,
	// stream in, towards the far side
	input  axis_stream_pkg::data_t   as_is_tdata,
	input  axis_stream_pkg::strb_t   as_is_tstrb,
	input  axis_stream_pkg::strb_t   as_is_tkeep,
	input  axis_stream_pkg::id_t     as_is_tid,
	input  axis_stream_pkg::user_t   as_is_tuser,
	input  logic                     as_is_tlast,
	input  logic                     as_is_tvalid,
	input  logic                     as_is_tready,
	// serial pins
	output serdes_lane_pkg::serial_t serial_txd,
	input  serdes_lane_pkg::serial_t serial_rxd,
	// stream out, from the far side
	output axis_stream_pkg::data_t   is_as_tdata,
	output axis_stream_pkg::strb_t   is_as_tstrb,
	output axis_stream_pkg::strb_t   is_as_tkeep,
	output axis_stream_pkg::id_t     is_as_tid,
	output axis_stream_pkg::user_t   is_as_tuser,
	output logic                     is_as_tlast,
	output logic                     is_as_tvalid,
	output logic                     is_as_tready
);
	import serdes_lane_pkg::*;

	phase_t phase;
	logic   txen;
	logic   rxen;
	logic   rx_flow_seen;
	logic   remote_tready;

	////////////////////////////////////////
	// link control
	////////////////////////////////////////

	link_control u_link_control (
		.ioclk         (ioclk),
		.axis_rst_n    (axis_rst_n),
		.txen_ctl      (txen_ctl),
		.rxen_ctl      (rxen_ctl),
		.rx_flow_seen  (rx_flow_seen),
		.remote_tready (remote_tready),
		.phase         (phase),
		.txen          (txen),
		.rxen          (rxen),
		.is_as_tready  (is_as_tready)
	);

	////////////////////////////////////////
	// transmit and receive paths
	////////////////////////////////////////

	tx_serializer u_tx_serializer (
		.ioclk        (ioclk),
		.axis_rst_n   (axis_rst_n),
		.txen         (txen),
		.phase        (phase),
		.as_is_tdata  (as_is_tdata),
		.as_is_tstrb  (as_is_tstrb),
		.as_is_tkeep  (as_is_tkeep),
		.as_is_tid    (as_is_tid),
		.as_is_tuser  (as_is_tuser),
		.as_is_tlast  (as_is_tlast),
		.as_is_tvalid (as_is_tvalid),
		.as_is_tready (as_is_tready),
		.is_as_tready (is_as_tready), // local ready gates the sent tvalid
		.serial_txd   (serial_txd)
	);

	rx_deserializer u_rx_deserializer (
		.ioclk         (ioclk),
		.axis_rst_n    (axis_rst_n),
		.rxen          (rxen),
		.phase         (phase),
		.serial_rxd    (serial_rxd),
		.is_as_tdata   (is_as_tdata),
		.is_as_tstrb   (is_as_tstrb),
		.is_as_tkeep   (is_as_tkeep),
		.is_as_tid     (is_as_tid),
		.is_as_tuser   (is_as_tuser),
		.is_as_tlast   (is_as_tlast),
		.is_as_tvalid  (is_as_tvalid),
		.remote_tready (remote_tready),
		.rx_flow_seen  (rx_flow_seen)
	);

endmodule

//--- source/rx_deserializer.sv
`timescale 1ns/1ps

module rx_deserializer (
	input  logic                     ioclk,
	input  logic                     axis_rst_n,
	input  logic                     rxen,
	input  serdes_lane_pkg::phase_t  phase,
	input  serdes_lane_pkg::serial_t serial_rxd,
	output axis_stream_pkg::data_t   is_as_tdata,
	output axis_stream_pkg::strb_t   is_as_tstrb,
	output axis_stream_pkg::strb_t   is_as_tkeep,
	output axis_stream_pkg::id_t     is_as_tid,
	output axis_stream_pkg::user_t   is_as_tuser,
	output logic                     is_as_tlast,
	output logic                     is_as_tvalid,
	output logic                     remote_tready,
	output logic                     rx_flow_seen
);
	import axis_stream_pkg::*;
	import serdes_lane_pkg::*;

	////////////////////////////////////////
	// lane sampling
	////////////////////////////////////////

	serial_t              sample_q [CLK_RATIO-1];   // lane vectors of the earlier phases
	logic [CLK_RATIO-1:0] lane_bits [SERIAL_WIDTH]; // per lane view of the frame
	data_t                data_nxt;

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			for (int p = 0; p < CLK_RATIO - 1; p++) begin
				sample_q[p] <= '0;
			end
		end else if (rxen && (phase != LAST_PHASE)) begin
			sample_q[phase] <= serial_rxd;
		end
	end

	// last bit of each lane comes straight from the pins
	// so the beat is registered on the same edge that samples it
	always_comb begin
		for (int l = 0; l < SERIAL_WIDTH; l++) begin
			for (int b = 0; b < CLK_RATIO - 1; b++) begin
				lane_bits[l][b] = sample_q[b][l];
			end
			lane_bits[l][LAST_PHASE] = serial_rxd[l];
		end
	end

	always_comb begin
		for (int j = 0; j < DATA_LANES; j++) begin
			data_nxt[j * CLK_RATIO +: CLK_RATIO] = lane_bits[j];
		end
	end

	////////////////////////////////////////
	// beat output
	////////////////////////////////////////

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			is_as_tdata   <= '0;
			is_as_tstrb   <= '0;
			is_as_tkeep   <= '0;
			is_as_tid     <= '0;
			is_as_tuser   <= '0;
			is_as_tlast   <= 1'b0;
			is_as_tvalid  <= 1'b0;
			remote_tready <= 1'b0;
			rx_flow_seen  <= 1'b0;
		end else if (!rxen) begin
			is_as_tdata   <= '0; // stream stays quiet while receive is off
			is_as_tstrb   <= '0;
			is_as_tkeep   <= '0;
			is_as_tid     <= '0;
			is_as_tuser   <= '0;
			is_as_tlast   <= 1'b0;
			is_as_tvalid  <= 1'b0;
			remote_tready <= 1'b0;
			rx_flow_seen  <= 1'b0;
		end else if (phase == LAST_PHASE) begin
			is_as_tdata               <= data_nxt;
			is_as_tstrb               <= lane_bits[LANE_STRB];
			is_as_tkeep               <= lane_bits[LANE_KEEP];
			{is_as_tid, is_as_tuser}  <= lane_bits[LANE_ID_USER];
			is_as_tlast               <= lane_bits[LANE_FLOW][2];
			is_as_tvalid              <= lane_bits[LANE_FLOW][1];
			remote_tready             <= lane_bits[LANE_FLOW][0];
			rx_flow_seen              <= |lane_bits[LANE_FLOW]; // far side is alive
		end else begin
			rx_flow_seen <= 1'b0; // one cycle pulse while the beat holds for the frame
		end
	end

endmodule

//--- source/tx_serializer.sv
`timescale 1ns/1ps

module tx_serializer (
	input  logic                     ioclk,
	input  logic                     axis_rst_n,
	input  logic                     txen,
	input  serdes_lane_pkg::phase_t  phase,
	input  axis_stream_pkg::data_t   as_is_tdata,
	input  axis_stream_pkg::strb_t   as_is_tstrb,
	input  axis_stream_pkg::strb_t   as_is_tkeep,
	input  axis_stream_pkg::id_t     as_is_tid,
	input  axis_stream_pkg::user_t   as_is_tuser,
	input  logic                     as_is_tlast,
	input  logic                     as_is_tvalid,
	input  logic                     as_is_tready,  // local ready, sent to the far side
	input  logic                     is_as_tready,  // ready from the far side, gates tvalid
	output serdes_lane_pkg::serial_t serial_txd
);
	import axis_stream_pkg::*;
	import serdes_lane_pkg::*;

	////////////////////////////////////////
	// frame register
	////////////////////////////////////////

	data_t                data_q;
	strb_t                strb_q;
	strb_t                keep_q;
	logic [CLK_RATIO-1:0] id_user_q; // {tid, tuser}
	logic [CLK_RATIO-1:0] flow_q;    // {0, tlast, tvalid, tready}

	// one beat per frame, captured on the frame boundary
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			data_q    <= '0;
			strb_q    <= '0;
			keep_q    <= '0;
			id_user_q <= '0;
			flow_q    <= '0;
		end else if (!txen) begin
			data_q    <= '0; // link idle, nothing to send
			strb_q    <= '0;
			keep_q    <= '0;
			id_user_q <= '0;
			flow_q    <= '0;
		end else if (phase == LAST_PHASE) begin
			data_q    <= as_is_tdata;
			strb_q    <= as_is_tstrb;
			keep_q    <= as_is_tkeep;
			id_user_q <= {as_is_tid, as_is_tuser};
			// a beat offered without ready goes out as a bubble
			flow_q    <= {1'b0, as_is_tlast, as_is_tvalid & is_as_tready, as_is_tready};
		end
	end

	////////////////////////////////////////
	// lane select
	////////////////////////////////////////

	// every lane sends its bit number phase, all lanes quiet while txen is low
	always_comb begin
		serial_txd = '0;
		if (txen) begin
			for (int j = 0; j < DATA_LANES; j++) begin
				serial_txd[j] = data_q[j * CLK_RATIO + int'(phase)];
			end
			serial_txd[LANE_STRB]    = strb_q[phase];
			serial_txd[LANE_KEEP]    = keep_q[phase];
			serial_txd[LANE_ID_USER] = id_user_q[phase];
			serial_txd[LANE_FLOW]    = flow_q[phase];
		end
	end

endmodule

//--- source/link_control.sv
`timescale 1ns/1ps

module link_control (
	input  logic                    ioclk,
	input  logic                    axis_rst_n,
	input  logic                    txen_ctl,
	input  logic                    rxen_ctl,
	input  logic                    rx_flow_seen,  // pulse per nonzero flow frame
	input  logic                    remote_tready, // ready sent by the far side
	output serdes_lane_pkg::phase_t phase,
	output logic                    txen,
	output logic                    rxen,
	output logic                    is_as_tready
);
	import serdes_lane_pkg::*;

	logic rx_received; // far side has been heard at least once

	// free running frame phase
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			phase <= '0;
		end else if (phase == LAST_PHASE) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// transmit starts on a frame boundary, also when the far side came up first
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			txen <= 1'b0;
		end else if ((phase == LAST_PHASE) && (txen_ctl || rx_received)) begin
			txen <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rxen <= 1'b0;
		end else if (rxen_ctl) begin
			rxen <= 1'b1;
		end
	end

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rx_received <= 1'b0;
		end else if (rx_flow_seen) begin
			rx_received <= 1'b1;
		end
	end

	// local ready: held high until the far side reports its own ready,
	// so neither side waits on the other at start up
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			is_as_tready <= 1'b0;
		end else if (!txen) begin
			is_as_tready <= 1'b0;
		end else if (!rx_received) begin
			is_as_tready <= 1'b1;
		end else begin
			is_as_tready <= remote_tready;
		end
	end

endmodule

//--- source/serdes_lane_pkg.sv
package serdes_lane_pkg;

	////////////////////////////////////////
	// frame timing
	////////////////////////////////////////

	// ioclk cycles per frame, also bits per lane per frame
	localparam int CLK_RATIO = 4;

	typedef logic [$clog2(CLK_RATIO)-1:0] phase_t;

	localparam phase_t LAST_PHASE = phase_t'(CLK_RATIO - 1); // frame boundary phase

	////////////////////////////////////////
	// lane map
	////////////////////////////////////////

	// data lane j carries tdata bits 4j..4j+3, one bit per phase
	localparam int DATA_LANES = axis_stream_pkg::DATA_WIDTH / CLK_RATIO;

	localparam int LANE_STRB    = DATA_LANES;     // tstrb
	localparam int LANE_KEEP    = DATA_LANES + 1; // tkeep
	localparam int LANE_ID_USER = DATA_LANES + 2; // {tid, tuser}

	// flow lane bits: 0 tready, 1 tvalid, 2 tlast, 3 unused and sent as 0
	localparam int LANE_FLOW = DATA_LANES + 3;

	localparam int SERIAL_WIDTH = DATA_LANES + 4; // total lane count

	typedef logic [SERIAL_WIDTH-1:0] serial_t;

endpackage

//--- source/axis_stream_pkg.sv
package axis_stream_pkg;

	////////////////////////////////////////
	// stream beat widths
	////////////////////////////////////////

	localparam int DATA_WIDTH = 32;             // stream data word
	localparam int STRB_WIDTH = DATA_WIDTH / 8; // one strobe bit per byte
	localparam int ID_WIDTH   = 2;
	localparam int USER_WIDTH = 2;

	////////////////////////////////////////
	// stream beat field types
	////////////////////////////////////////

	// tdata payload
	typedef logic [DATA_WIDTH-1:0] data_t;

	// shared by tstrb and tkeep
	typedef logic [STRB_WIDTH-1:0] strb_t;

	typedef logic [ID_WIDTH-1:0]   id_t;   // stream id
	typedef logic [USER_WIDTH-1:0] user_t; // user sideband

endpackage
